// File: logic/clkdiv_pkg.sv
package clkdiv_pkg;

    // The APB slave decodes a 4 KB window
    localparam int APB_ADDR_WIDTH = 12;
    localparam int APB_DATA_WIDTH = 32;

    // Each channel is steered by one divisor of this width
    localparam int DIV_WIDTH = 8;

    // Zero bits that pad a divisor up to a full APB read word
    localparam int DATA_PAD_WIDTH = APB_DATA_WIDTH - DIV_WIDTH;

    // Only this address bit picks a register, so the two registers
    // alias across the whole window
    localparam int REG_SEL_BIT = 2;

    // Register select codes, as seen on address bit 2
    localparam logic REG_CLKDIV0 = 1'b0; // Offset 0x00, channel 0 divisor
    localparam logic REG_CLKDIV1 = 1'b1; // Offset 0x04, channel 1 divisor

endpackage

// File: logic/apb_clkdiv.sv
module apb_clkdiv
    import clkdiv_pkg::*;
(
    input  logic                      HCLK,
    input  logic                      HRESETn,
    input  logic [APB_ADDR_WIDTH-1:0] paddr,
    input  logic [APB_DATA_WIDTH-1:0] pwdata,
    input  logic                      pwrite,
    input  logic                      psel,
    input  logic                      penable,
    output logic [APB_DATA_WIDTH-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr,

    output logic [DIV_WIDTH-1:0]      div0,
    output logic                      div0_valid,
    output logic [DIV_WIDTH-1:0]      div1,
    output logic                      div1_valid
);

    logic [DIV_WIDTH-1:0] div0_q;
    logic [DIV_WIDTH-1:0] div1_q;
    logic                 div0_valid_q;
    logic                 div1_valid_q;

    logic                 reg_sel;
    logic                 apb_write;
    logic                 wr_div0;
    logic                 wr_div1;

    assign reg_sel   = paddr[REG_SEL_BIT];

    // A write completes in its access phase since there are no wait states
    assign apb_write = psel & penable & pwrite;

    assign wr_div0   = apb_write & (reg_sel == REG_CLKDIV0);
    assign wr_div1   = apb_write & (reg_sel == REG_CLKDIV1);

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            div0_q <= '0;
            div1_q <= '0;
        end
        else
        begin
            if (wr_div0)
            begin
                div0_q <= pwdata[DIV_WIDTH-1:0]; // Upper write bits are dropped
            end
            if (wr_div1)
            begin
                div1_q <= pwdata[DIV_WIDTH-1:0];
            end
        end
    end

    // Update flags are high for exactly the cycle after the write
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            div0_valid_q <= 1'b0;
            div1_valid_q <= 1'b0;
        end
        else
        begin
            div0_valid_q <= wr_div0;
            div1_valid_q <= wr_div1;
        end
    end

    // Read data follows the address with no added latency
    always_comb
    begin
        case (reg_sel)
            REG_CLKDIV0: prdata = {{DATA_PAD_WIDTH{1'b0}}, div0_q};
            REG_CLKDIV1: prdata = {{DATA_PAD_WIDTH{1'b0}}, div1_q};
            default:     prdata = '0;
        endcase
    end

    assign div0       = div0_q;
    assign div0_valid = div0_valid_q;
    assign div1       = div1_q;
    assign div1_valid = div1_valid_q;

    assign pready  = 1'b1;
    assign pslverr = 1'b0;

endmodule

// File: logic/clk_divider.sv
module clk_divider
    import clkdiv_pkg::*;
(
    input  logic                 HCLK,
    input  logic                 HRESETn,
    input  logic [DIV_WIDTH-1:0] div,
    input  logic                 div_valid,
    output logic                 clk_out
);

    logic [DIV_WIDTH-1:0] cnt_q;
    logic [DIV_WIDTH-1:0] cnt_d;
    logic                 clk_q;
    logic                 clk_d;

    logic                 div_zero;
    logic                 cnt_done;
    logic                 reload;
    logic                 toggle;

    assign div_zero = (div == '0);
    assign cnt_done = (cnt_q == '0);

    // An update restarts the count from the new divisor, as does the end of
    // a half period
    assign reload = ~div_zero & (div_valid | cnt_done);

    // The output only flips at the end of a half period that was not
    // interrupted by an update
    assign toggle = ~div_zero & ~div_valid & cnt_done;

    // Down-counter spans div + 1 cycles per half period
    always_comb
    begin
        if (div_zero)
        begin
            cnt_d = '0; // Parked while the channel is off
        end
        else if (reload)
        begin
            cnt_d = div;
        end
        else
        begin
            cnt_d = cnt_q - 1'b1;
        end
    end

    always_comb
    begin
        if (div_zero || div_valid)
        begin
            clk_d = 1'b0;
        end
        else if (toggle)
        begin
            clk_d = ~clk_q;
        end
        else
        begin
            clk_d = clk_q;
        end
    end

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            cnt_q <= '0;
        end
        else
        begin
            cnt_q <= cnt_d;
        end
    end

    // The output is a plain flop in the HCLK domain
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            clk_q <= 1'b0;
        end
        else
        begin
            clk_q <= clk_d;
        end
    end

    assign clk_out = clk_q;

endmodule

// File: logic/clkdiv_subsys.sv
module clkdiv_subsys
    import clkdiv_pkg::*;
(
    input  logic                      HCLK,
    input  logic                      HRESETn,

    input  logic [APB_ADDR_WIDTH-1:0] paddr,
    input  logic [APB_DATA_WIDTH-1:0] pwdata,
    input  logic                      pwrite,
    input  logic                      psel,
    input  logic                      penable,
    output logic [APB_DATA_WIDTH-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr,

    output logic                      clk_out0,
    output logic                      clk_out1
);

    logic [DIV_WIDTH-1:0] div0;
    logic                 div0_valid;
    logic [DIV_WIDTH-1:0] div1;
    logic                 div1_valid;

    apb_clkdiv u_regs (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .pwrite     (pwrite),
        .psel       (psel),
        .penable    (penable),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .div0       (div0),
        .div0_valid (div0_valid),
        .div1       (div1),
        .div1_valid (div1_valid)
    );

    // Channel 0 follows the register at offset 0x00
    clk_divider u_div0 (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .div       (div0),
        .div_valid (div0_valid),
        .clk_out   (clk_out0)
    );

    // Channel 1 follows the register at offset 0x04
    clk_divider u_div1 (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .div       (div1),
        .div_valid (div1_valid),
        .clk_out   (clk_out1)
    );

endmodule

// File: verif/clkdiv_checker.sv
module clkdiv_checker
    import clkdiv_pkg::*;
(
    input logic                 HCLK,
    input logic                 HRESETn,
    input logic                 pready,
    input logic                 pslverr,
    input logic [DIV_WIDTH-1:0] div0,
    input logic                 div0_valid,
    input logic [DIV_WIDTH-1:0] div1,
    input logic                 div1_valid,
    input logic                 clk_out0,
    input logic                 clk_out1
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0; // Number of failed assertions so far

    a_apb_fixed: assert property (@(posedge HCLK) disable iff (!HRESETn) pready && !pslverr)
        else
        begin
            fail_count++;
            $error("pready or pslverr left its fixed level");
        end

    a_valid0_pulse: assert property (@(posedge HCLK) disable iff (!HRESETn)
                                     div0_valid |=> !div0_valid)
        else
        begin
            fail_count++;
            $error("div0_valid stayed high for two cycles");
        end

    a_valid1_pulse: assert property (@(posedge HCLK) disable iff (!HRESETn)
                                     div1_valid |=> !div1_valid)
        else
        begin
            fail_count++;
            $error("div1_valid stayed high for two cycles");
        end

    // The output flop needs one edge to fall after the divisor turns zero
    a_zero0_low: assert property (@(posedge HCLK) disable iff (!HRESETn)
                                  (div0 == '0) && $past(div0 == '0) |-> !clk_out0)
        else
        begin
            fail_count++;
            $error("clk_out0 high while its divisor is zero");
        end

    a_zero1_low: assert property (@(posedge HCLK) disable iff (!HRESETn)
                                  (div1 == '0) && $past(div1 == '0) |-> !clk_out1)
        else
        begin
            fail_count++;
            $error("clk_out1 high while its divisor is zero");
        end

endmodule

bind clkdiv_subsys clkdiv_checker u_checker (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .pready     (pready),
    .pslverr    (pslverr),
    .div0       (div0),
    .div0_valid (div0_valid),
    .div1       (div1),
    .div1_valid (div1_valid),
    .clk_out0   (clk_out0),
    .clk_out1   (clk_out1)
);

// File: verif/tb_clkdiv.sv
module tb_clkdiv
    import clkdiv_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        string                     name;
        logic [APB_ADDR_WIDTH-1:0] addr;
        logic [APB_DATA_WIDTH-1:0] wdata;
        logic [APB_DATA_WIDTH-1:0] exp_rd0;
        logic [APB_DATA_WIDTH-1:0] exp_rd1;
        int                        exp_per0;
        int                        exp_per1;
    } test_t;

    logic                      HCLK;
    logic                      HRESETn;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
    logic                      pwrite;
    logic                      psel;
    logic                      penable;
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
    logic                      clk_out0;
    logic                      clk_out1;

    test_t                tests[$];
    logic [DIV_WIDTH-1:0] model_div0 = '0; // Divisors as software expects them
    logic [DIV_WIDTH-1:0] model_div1 = '0;
    int                   seed = 32'ha9c2719f;
    int                   timeout_limit = 200;
    int                   cycle_count = 0;

    clkdiv_subsys u_clkdiv_subsys (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .pwrite   (pwrite),
        .psel     (psel),
        .penable  (penable),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .clk_out0 (clk_out0),
        .clk_out1 (clk_out1)
    );

    initial
    begin
        HCLK = 1'b0;
        forever #50 HCLK = ~HCLK;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    always @(posedge HCLK)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > timeout_limit)
            abort_run($sformatf("Timeout after %0d cycles, the tests did not finish", cycle_count));
        if (u_clkdiv_subsys.u_checker.fail_count != 0)
            abort_run("A checker assertion failed, see the error above");
    end

    task automatic check_data(input string name, input logic [APB_DATA_WIDTH-1:0] exp,
                              input logic [APB_DATA_WIDTH-1:0] act);
        if (act !== exp)
            abort_run($sformatf("Mismatch in %s: expected 0x%08h, actual 0x%08h", name, exp, act));
    endtask

    task automatic check_period(input string name, input int exp, input int act);
        if (act != exp)
            abort_run($sformatf("Mismatch in %s: expected %0d cycles, actual %0d cycles",
                                name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
    endtask

    // A period is 2 x (divisor + 1) cycles, and zero means the output is held low
    function automatic int expected_period(input logic [DIV_WIDTH-1:0] d);
        return (d == '0) ? 0 : 2 * (int'(d) + 1);
    endfunction

    function automatic logic sample_out(input int ch);
        return (ch == 0) ? clk_out0 : clk_out1;
    endfunction

    task automatic add_test(input string name, input logic [APB_ADDR_WIDTH-1:0] addr,
                            input logic [APB_DATA_WIDTH-1:0] wdata);
        test_t t;
        if (addr[2] == REG_CLKDIV1)
            model_div1 = wdata[DIV_WIDTH-1:0];
        else
            model_div0 = wdata[DIV_WIDTH-1:0];
        t.name     = name;
        t.addr     = addr;
        t.wdata    = wdata;
        t.exp_rd0  = {{(APB_DATA_WIDTH-DIV_WIDTH){1'b0}}, model_div0};
        t.exp_rd1  = {{(APB_DATA_WIDTH-DIV_WIDTH){1'b0}}, model_div1};
        t.exp_per0 = expected_period(model_div0);
        t.exp_per1 = expected_period(model_div1);
        tests.push_back(t);
        // Each entry follows the restart of the written channel and then
        // measures both channels, so all of these spans add to the limit
        timeout_limit += 4 * (int'(model_div0) + 1) + 4 * (int'(model_div1) + 1)
                         + int'(wdata[DIV_WIDTH-1:0]) + 60;
    endtask

    task automatic build_table();
        logic [31:0]          rnd;
        logic [DIV_WIDTH-1:0] d;
        logic                 ch_sel;
        add_test("write_ch0", 12'h000, 32'h0000_0003);
        add_test("write_ch1_upper", 12'h004, 32'hABCD_1205);
        add_test("alias_ch1_0x104", 12'h104, 32'h0000_5A02);
        add_test("alias_ch0_0xff0", 12'hFF0, 32'h0000_0001);
        for (int i = 0; i < 4; i++)
        begin
            rnd    = $random(seed);
            d      = rnd[DIV_WIDTH-1:0];
            ch_sel = i[0];
            if (d == '0)
                d = 8'd1;
            add_test($sformatf("random_%0d", i), {rnd[19:11], ch_sel, 2'b00}, {rnd[31:8], d});
        end
        add_test("restart_ch0", 12'h000, 32'h0000_0007);
        add_test("restart_ch1", 12'h004, 32'h0000_000A);
        add_test("zero_ch0", 12'h008, 32'h0000_0000);
        add_test("zero_ch1", 12'h004, 32'hFFFF_FF00);
    endtask

    task automatic apb_write(input logic [APB_ADDR_WIDTH-1:0] addr,
                             input logic [APB_DATA_WIDTH-1:0] data);
        @(posedge HCLK);
        #10;
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge HCLK);
        #10;
        penable = 1'b1;
        @(posedge HCLK); // Write lands on this edge
        #10;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_and_check(input string name, input logic [APB_ADDR_WIDTH-1:0] addr,
                                  input logic [APB_DATA_WIDTH-1:0] exp);
        @(posedge HCLK);
        #10;
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge HCLK);
        #10;
        penable = 1'b1;
        @(negedge HCLK);
        check_data(name, exp, prdata);
        check_flag({name, "/pready"}, 1'b1, pready);
        check_flag({name, "/pslverr"}, 1'b0, pslverr);
        @(posedge HCLK);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic hold_low(input string name, input int ch, input int cycles);
        repeat (cycles)
        begin
            @(negedge HCLK);
            check_flag($sformatf("%s/clk_out%0d_low", name, ch), 1'b0, sample_out(ch));
        end
    endtask

    // Called right after the write edge. The divider sees the update one edge
    // later, holds the output low for divisor + 1 cycles and then raises it
    task automatic check_restart(input string name, input int ch, input int exp);
        @(negedge HCLK); // Update not yet seen by the divider
        repeat (exp / 2)
        begin
            @(negedge HCLK);
            check_flag($sformatf("%s/clk_out%0d_restart_low", name, ch), 1'b0,
                       sample_out(ch));
        end
        @(negedge HCLK);
        check_flag($sformatf("%s/clk_out%0d_restart_high", name, ch), 1'b1, sample_out(ch));
    endtask

    // Counts cycles between two consecutive rising edges of one output
    task automatic measure_period(input string name, input int ch, input int exp,
                                  output int period);
        int   limit;
        int   waited;
        logic prev;
        logic cur;
        bit   found;
        limit  = 2 * exp + 8;
        waited = 0;
        found  = 1'b0;
        @(negedge HCLK);
        prev = sample_out(ch);
        while (!found && waited < limit)
        begin
            @(negedge HCLK);
            cur   = sample_out(ch);
            found = !prev && cur;
            prev  = cur;
            waited++;
        end
        if (!found)
            abort_run($sformatf("Test %s saw no rising edge on clk_out%0d within %0d cycles",
                                name, ch, limit));
        period = 0;
        found  = 1'b0;
        while (!found && period < limit)
        begin
            @(negedge HCLK);
            cur   = sample_out(ch);
            found = !prev && cur;
            prev  = cur;
            period++;
        end
    endtask

    initial
    begin
        test_t t;
        int    exp;
        int    period;
        int    wr_ch;
        HRESETn = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        pwrite  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        build_table();
        repeat (3) @(posedge HCLK);
        #10;
        HRESETn = 1'b1;

        read_and_check("reset/rd0", 12'h000, 32'h0);
        read_and_check("reset/rd1", 12'h004, 32'h0);
        hold_low("reset", 0, 20);
        hold_low("reset", 1, 20);

        for (int i = 0; i < tests.size(); i++)
        begin
            t = tests[i];
            apb_write(t.addr, t.wdata);
            wr_ch = (t.addr[2] == REG_CLKDIV1) ? 1 : 0;
            exp   = (wr_ch == 0) ? t.exp_per0 : t.exp_per1;
            if (exp != 0)
                check_restart(t.name, wr_ch, exp);
            read_and_check({t.name, "/rd0"}, 12'h000, t.exp_rd0);
            read_and_check({t.name, "/rd1"}, 12'h004, t.exp_rd1);
            for (int ch = 0; ch < 2; ch++)
            begin
                exp = (ch == 0) ? t.exp_per0 : t.exp_per1;
                if (exp == 0)
                begin
                    hold_low(t.name, ch, 20);
                end
                else
                begin
                    measure_period(t.name, ch, exp, period);
                    check_period($sformatf("%s/period%0d", t.name, ch), exp, period);
                end
            end
        end

        if (u_clkdiv_subsys.u_checker.fail_count != 0)
        begin
            abort_run("A checker assertion failed, see the error above");
        end
        else
        begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// File: all.f
logic/clkdiv_pkg.sv
logic/apb_clkdiv.sv
logic/clk_divider.sv
logic/clkdiv_subsys.sv
verif/clkdiv_checker.sv
verif/tb_clkdiv.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the clock divider testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
FAIL_MSG="tests failed"

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module tb_clkdiv \
    -Mdir "$OBJ_DIR" -o tb_clkdiv \
    -f all.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$OBJ_DIR/tb_clkdiv" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status, see $LOG"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
